// File: boot_image.hex
// One 128-bit cache line per row starting at line 0
// The rightmost 8 digits of a row form beat 0 of that line
27bdfff0afbf000c3c1c80003c088000
8d0900048d0a00082129000101495021
ad0a000c240b0010156bfffa2508ffff
3c0480003484010024050020240600ff
a0860000248400012405ffff14a0fffd
0c0000408fbf000c27bd001003e00008
deadbeef0badf00dcafef00d12345678
5a5aa5a5c3c33c3c0f0ff0f096966969

// File: logic/biu_wb_master.sv
`timescale 1ns/1ps
`default_nettype none

module biu_wb_master
    import wb_pkg::*;
    import boot_pkg::*;
(
    input  logic     i_wb_clk,
    input  logic     i_rst_n,

    // Line request from the boot controller
    input  logic     i_biu_en,
    input  wb_addr_t i_biu_addr,
    input  line_t    i_biu_line,
    output logic     o_biu_done,

    // Wishbone master
    input  logic     i_wb_ack,
    output wb_req_t  o_wb
);

    typedef enum logic [1:0] {
        BIU_IDLE  = 2'b00,
        BIU_BURST = 2'b01,
        BIU_DONE  = 2'b10
    } biu_state_e;

    biu_state_e state_r;
    biu_state_e state_next;

    beat_idx_t  beat_idx_r;
    beat_idx_t  beat_idx_next;

    line_t      line_r;                             // Captured line payload
    wb_addr_t   base_addr_r;

    logic       busy;
    logic       start;
    logic       beat_ack;
    logic       last_beat;
    wb_addr_t   beat_addr;
    wb_data_t   beat_data;

    // ----------------------------------------------------------
    // Burst control
    // ----------------------------------------------------------
    assign busy      = (state_r == BIU_BURST);
    assign start     = (state_r == BIU_IDLE) & i_biu_en;
    assign beat_ack  = busy & i_wb_ack;
    assign last_beat = (beat_idx_r == beat_idx_t'(BEATS_PER_LINE - 1));

    always_comb begin
        state_next = state_r;

        case (state_r)
            BIU_IDLE: begin
                if (i_biu_en) begin
                    state_next = BIU_BURST;
                end
            end
            BIU_BURST: begin
                if (i_wb_ack && last_beat) begin
                    state_next = BIU_DONE;
                end
            end
            // Single cycle, lets the enable drop before going idle
            BIU_DONE: begin
                state_next = BIU_IDLE;
            end
            default: begin
                state_next = BIU_IDLE;
            end
        endcase
    end

    always_comb begin
        beat_idx_next = beat_idx_r;

        if (state_r != BIU_BURST) begin
            beat_idx_next = '0;
        end else if (beat_ack) begin
            beat_idx_next = beat_idx_r + 1'b1;      // Advance only on ack
        end
    end

    always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r    <= BIU_IDLE;
            beat_idx_r <= '0;
        end else begin
            state_r    <= state_next;
            beat_idx_r <= beat_idx_next;
        end
    end

    // ----------------------------------------------------------
    // Line capture
    // ----------------------------------------------------------
    always_ff @(posedge i_wb_clk) begin
        if (start) begin
            line_r      <= i_biu_line;
            base_addr_r <= i_biu_addr;
        end
    end

    // Word of the line for the current beat
    assign beat_data = line_r[beat_idx_r*WB_DATA_W +: WB_DATA_W];
    assign beat_addr = base_addr_r + wb_addr_t'(beat_idx_r) * wb_addr_t'(WB_SEL_W);

    // ----------------------------------------------------------
    // Bus outputs
    // ----------------------------------------------------------
    always_comb begin
        o_wb.cyc  = busy;                           // Held across all beats
        o_wb.stb  = busy;
        o_wb.we   = busy;
        o_wb.cti  = last_beat ? WB_CTI_EOB : WB_CTI_INCR;
        o_wb.bte  = WB_BTE_LINEAR;
        o_wb.sel  = '1;
        o_wb.addr = beat_addr;
        o_wb.data = beat_data;
    end

    assign o_biu_done = (state_r == BIU_DONE);

    // ----------------------------------------------------------
    // Protocol checks
    // ----------------------------------------------------------
    a_stb_in_cyc: assert property (
        @(posedge i_wb_clk) disable iff (!i_rst_n)
        o_wb.stb |-> o_wb.cyc
    ) else $error("biu_wb_master: stb without cyc");

    // A stalled beat must not move
    a_stall_stable: assert property (
        @(posedge i_wb_clk) disable iff (!i_rst_n)
        (o_wb.stb && !i_wb_ack) |=>
            ($stable(o_wb.addr) && $stable(o_wb.data) && $stable(o_wb.cti))
    ) else $error("biu_wb_master: beat changed while stalled");

endmodule

`default_nettype wire

// File: logic/boot_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module boot_ctrl
    import wb_pkg::*;
    import boot_pkg::*;
(
    input  logic      i_wb_clk,
    input  logic      i_rst_n,

    // ROM side
    input  line_t     i_rom_line,
    output rom_addr_t o_rom_addr,

    // Bus unit side
    output logic      o_biu_en,
    output wb_addr_t  o_biu_addr,
    output line_t     o_biu_line,
    input  logic      i_biu_done,

    output logic      o_boot_done
);

    boot_state_e state_r;
    boot_state_e state_next;

    rom_addr_t   rom_idx_r;                         // Line being written
    rom_addr_t   rom_idx_next;

    logic        biu_en_r;
    logic        biu_en_next;
    line_t       line_r;
    logic        last_line;

    assign last_line = (rom_idx_r == rom_addr_t'(HEX_LINES - 1));

    // ----------------------------------------------------------
    // Sequencer
    // ----------------------------------------------------------
    always_comb begin
        state_next   = state_r;
        rom_idx_next = rom_idx_r;
        biu_en_next  = 1'b0;

        case (state_r)
            BOOT_RESET: begin
                rom_idx_next = '0;
                state_next   = BOOT_BUSY;
            end
            BOOT_BUSY: begin
                // Enable gap of one cycle after each done pulse
                biu_en_next = ~i_biu_done;
                if (i_biu_done) begin
                    rom_idx_next = rom_idx_r + 1'b1;
                    if (last_line) begin
                        state_next = BOOT_DONE;
                    end
                end
            end
            BOOT_DONE: begin
                rom_idx_next = '0;
            end
            default: begin
                state_next = BOOT_DONE;
            end
        endcase
    end

    always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r   <= BOOT_RESET;
            rom_idx_r <= '0;
            biu_en_r  <= 1'b0;
        end else begin
            state_r   <= state_next;
            rom_idx_r <= rom_idx_next;
            biu_en_r  <= biu_en_next;
        end
    end

    // ROM line for the current index, ready before the enable rises
    always_ff @(posedge i_wb_clk) begin
        line_r <= i_rom_line;
    end

    // ----------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------
    assign o_rom_addr  = rom_idx_r;
    assign o_biu_en    = biu_en_r;
    assign o_biu_addr  = wb_addr_t'(rom_idx_r) << LINE_OFFSET_W;
    assign o_biu_line  = line_r;
    assign o_boot_done = (state_r == BOOT_DONE);

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    a_done_sticky: assert property (
        @(posedge i_wb_clk) disable iff (!i_rst_n)
        o_boot_done |=> o_boot_done
    ) else $error("boot_ctrl: boot done dropped");

    a_no_en_when_done: assert property (
        @(posedge i_wb_clk) disable iff (!i_rst_n)
        (state_r == BOOT_DONE) |-> !o_biu_en
    ) else $error("boot_ctrl: bus unit enabled after boot");

endmodule

`default_nettype wire

// File: logic/boot_pkg.sv
`default_nettype none

package boot_pkg;

    import wb_pkg::*;

    // ----------------------------------------------------------
    // Boot image geometry
    // ----------------------------------------------------------
    localparam int LINE_BYTES     = 16;
    localparam int HEX_LINES      = 8;                          // Lines in the image
    localparam int BEATS_PER_LINE = LINE_BYTES / (WB_DATA_W / 8);
    localparam int LINE_OFFSET_W  = $clog2(LINE_BYTES);         // Byte offset in a line

    typedef logic [LINE_BYTES*8-1:0]            line_t;
    typedef logic [$clog2(HEX_LINES)-1:0]      rom_addr_t;     // Line index
    typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_idx_t;

    // ----------------------------------------------------------
    // Boot sequencer states
    // ----------------------------------------------------------
    // RESET only lasts one cycle after reset release, BUSY walks
    // the image line by line and DONE is terminal until the next
    // reset.
    typedef enum logic [1:0] {
        BOOT_RESET = 2'b00,
        BOOT_BUSY  = 2'b01,
        BOOT_DONE  = 2'b10
    } boot_state_e;

endpackage

`default_nettype wire

// File: logic/boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

module boot_rom
    import boot_pkg::*;
(
    input  rom_addr_t i_rom_addr,
    output line_t     o_rom_line
);

    // ----------------------------------------------------------
    // Image storage
    // ----------------------------------------------------------
    line_t rom_mem [HEX_LINES];                     // One entry per cache line

    // Image is fixed at elaboration
    initial begin
        $readmemh("boot_image.hex", rom_mem);
    end

    // ----------------------------------------------------------
    // Read port
    // ----------------------------------------------------------
    // Asynchronous lookup; the controller registers the line
    // itself, so the ROM adds no latency of its own.
    always_comb begin
        o_rom_line = rom_mem[i_rom_addr];
    end

endmodule

`default_nettype wire

// File: logic/boot_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module boot_subsys_top
    import wb_pkg::*;
    import boot_pkg::*;
(
    input  logic    i_wb_clk,
    input  logic    i_rst_n,
    input  logic    i_wb_ack,
    output wb_req_t o_wb,
    output logic    o_boot_done
);

    rom_addr_t rom_addr;
    line_t     rom_line;

    logic      biu_en;
    wb_addr_t  biu_addr;
    line_t     biu_line;
    logic      biu_done;

    // ----------------------------------------------------------
    // Image store, sequencer and bus master
    // ----------------------------------------------------------
    boot_rom rom_i (
        .i_rom_addr (rom_addr),
        .o_rom_line (rom_line)
    );

    boot_ctrl ctrl_i (
        .i_wb_clk    (i_wb_clk),
        .i_rst_n     (i_rst_n),
        .i_rom_line  (rom_line),
        .o_rom_addr  (rom_addr),
        .o_biu_en    (biu_en),
        .o_biu_addr  (biu_addr),
        .o_biu_line  (biu_line),
        .i_biu_done  (biu_done),
        .o_boot_done (o_boot_done)
    );

    biu_wb_master biu_i (
        .i_wb_clk   (i_wb_clk),
        .i_rst_n    (i_rst_n),
        .i_biu_en   (biu_en),
        .i_biu_addr (biu_addr),
        .i_biu_line (biu_line),
        .o_biu_done (biu_done),
        .i_wb_ack   (i_wb_ack),
        .o_wb       (o_wb)
    );

endmodule

`default_nettype wire

// File: logic/wb_pkg.sv
`default_nettype none

package wb_pkg;

    // ----------------------------------------------------------
    // Bus geometry
    // ----------------------------------------------------------
    localparam int WB_DATA_W = 32;
    localparam int WB_ADDR_W = 32;
    localparam int WB_SEL_W  = WB_DATA_W / 8;       // One select bit per byte

    typedef logic [WB_DATA_W-1:0] wb_data_t;
    typedef logic [WB_ADDR_W-1:0] wb_addr_t;        // Byte address
    typedef logic [WB_SEL_W-1:0]  wb_sel_t;
    typedef logic [2:0]           wb_cti_t;
    typedef logic [1:0]           wb_bte_t;

    // ----------------------------------------------------------
    // Registered feedback cycle codes
    // ----------------------------------------------------------
    localparam wb_cti_t WB_CTI_INCR   = 3'b010;     // Incrementing burst
    localparam wb_cti_t WB_CTI_EOB    = 3'b111;     // Last beat of a burst
    localparam wb_bte_t WB_BTE_LINEAR = 2'b00;

    // Master side of the bus, one struct per port
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_cti_t  cti;
        wb_bte_t  bte;
        wb_sel_t  sel;
        wb_addr_t addr;
        wb_data_t data;
    } wb_req_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the boot subsystem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_boot_subsys -Mdir obj_dir -o sim_boot \
    && ./obj_dir/sim_boot | tee /dev/stderr | grep -qx "test passed" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: sources.f
logic/wb_pkg.sv
logic/boot_pkg.sv
logic/boot_rom.sv
logic/biu_wb_master.sv
logic/boot_ctrl.sv
logic/boot_subsys_top.sv
testbench/wb_mem_model.sv
testbench/tb_boot_subsys.sv

// File: testbench/tb_boot_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_boot_subsys
    import wb_pkg::*;
    import boot_pkg::*;
();

    localparam time CLK_PERIOD   = 20;
    localparam time DRIVE_DLY    = 2;
    localparam int  RESET_CYCLES = 5;
    localparam int  TOTAL_BEATS  = HEX_LINES * BEATS_PER_LINE;
    localparam int  DONE_TIMEOUT = 2000;
    localparam int  IDLE_CYCLES  = 20;
    localparam logic [WB_SEL_W+2:0] EXP_ATTRS = {1'b1, {WB_SEL_W{1'b1}}, WB_BTE_LINEAR};

    logic        wb_clk;
    logic        rst_n;
    logic        wb_ack;
    wb_req_t     wb;
    logic        boot_done;
    logic [15:0] beat_cnt;
    wb_addr_t    peek_addr;
    wb_data_t    peek_data;

    line_t       image [HEX_LINES];                 // Expected boot image
    int          err_cnt = 0;

    int          exp_line;
    int          exp_beat;
    wb_addr_t    exp_addr;
    wb_data_t    exp_data;
    wb_cti_t     exp_cti;

    logic        rst_q;
    logic        stall_q;
    logic        in_burst;
    logic        done_q;
    logic [15:0] ack_cnt;
    wb_addr_t    prev_addr;
    wb_data_t    prev_data;
    wb_cti_t     prev_cti;

    // ----------------------------------------------------------
    // Clock, DUT and memory
    // ----------------------------------------------------------
    initial begin
        wb_clk = 1'b0;
        forever #(CLK_PERIOD / 2) wb_clk = ~wb_clk;
    end

    initial begin
        $readmemh("boot_image.hex", image);
    end

    boot_subsys_top dut_i (
        .i_wb_clk    (wb_clk),
        .i_rst_n     (rst_n),
        .i_wb_ack    (wb_ack),
        .o_wb        (wb),
        .o_boot_done (boot_done)
    );

    wb_mem_model mem_i (
        .i_clk       (wb_clk),
        .i_rst_n     (rst_n),
        .i_wb        (wb),
        .o_ack       (wb_ack),
        .o_beat_cnt  (beat_cnt),
        .i_peek_addr (peek_addr),
        .o_peek_data (peek_data)
    );

    task automatic report_mismatch(input string name, input logic [127:0] exp_val,
                                   input logic [127:0] act_val);
        err_cnt++;
        $display("Error: %s expected %0h actual %0h at %0t", name, exp_val, act_val, $time);
    endtask

    task automatic log_failure(input string what);
        err_cnt++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    // ----------------------------------------------------------
    // Expected beat from the image and the beat count
    // ----------------------------------------------------------
    always_comb begin
        exp_line = int'(beat_cnt) / BEATS_PER_LINE;
        exp_beat = int'(beat_cnt) % BEATS_PER_LINE;
        exp_addr = wb_addr_t'(exp_line * LINE_BYTES + exp_beat * (WB_DATA_W / 8));
        exp_cti  = (exp_beat == BEATS_PER_LINE - 1) ? WB_CTI_EOB : WB_CTI_INCR;
        if (exp_line < HEX_LINES) begin
            exp_data = image[exp_line][exp_beat*WB_DATA_W +: WB_DATA_W];
        end else begin
            exp_data = '0;
        end
    end

    always_ff @(posedge wb_clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_q    <= 1'b0;
            stall_q  <= 1'b0;
            in_burst <= 1'b0;
            done_q   <= 1'b0;
            ack_cnt  <= '0;
        end else begin
            rst_q    <= 1'b1;                       // Low for one cycle after release
            stall_q  <= wb.stb && !wb_ack;
            done_q   <= boot_done;
            if (wb.stb && wb_ack) begin
                in_burst <= (wb.cti != WB_CTI_EOB);
                ack_cnt  <= ack_cnt + 16'd1;
            end
        end
    end

    always_ff @(posedge wb_clk) begin
        prev_addr <= wb.addr;
        prev_data <= wb.data;
        prev_cti  <= wb.cti;
    end

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    a_quiet_reset: assert property (@(posedge wb_clk)
        !rst_q |-> (!wb.cyc && !wb.stb && !boot_done))
        else log_failure("bus or boot done active during or right after reset");

    a_beat_addr: assert property (@(posedge wb_clk) disable iff (!rst_n)
        (wb.stb && wb_ack) |-> (wb.addr == exp_addr))
        else report_mismatch("beat_addr", $sampled(exp_addr), $sampled(wb.addr));

    a_beat_data: assert property (@(posedge wb_clk) disable iff (!rst_n)
        (wb.stb && wb_ack) |-> (wb.data == exp_data))
        else report_mismatch("beat_data", $sampled(exp_data), $sampled(wb.data));

    a_beat_cti: assert property (@(posedge wb_clk) disable iff (!rst_n)
        (wb.stb && wb_ack) |-> (wb.cti == exp_cti))
        else report_mismatch("beat_cti", $sampled(exp_cti), $sampled(wb.cti));

    a_beat_range: assert property (@(posedge wb_clk) disable iff (!rst_n)
        (wb.stb && wb_ack) |-> (int'(beat_cnt) < TOTAL_BEATS))
        else log_failure("more beats written than the image holds");

    a_burst_attrs: assert property (@(posedge wb_clk) disable iff (!rst_n)
        wb.stb |-> ({wb.we, wb.sel, wb.bte} == EXP_ATTRS))
        else report_mismatch("burst_attrs", EXP_ATTRS, $sampled({wb.we, wb.sel, wb.bte}));

    a_burst_cyc: assert property (@(posedge wb_clk) disable iff (!rst_n)
        in_burst |-> wb.cyc)
        else log_failure("cyc dropped inside a burst");

    // Stalled beat holds still
    a_stall_addr: assert property (@(posedge wb_clk) disable iff (!rst_n)
        stall_q |-> (wb.addr == prev_addr))
        else report_mismatch("stall_addr", $sampled(prev_addr), $sampled(wb.addr));

    a_stall_data: assert property (@(posedge wb_clk) disable iff (!rst_n)
        stall_q |-> (wb.data == prev_data))
        else report_mismatch("stall_data", $sampled(prev_data), $sampled(wb.data));

    a_stall_cti: assert property (@(posedge wb_clk) disable iff (!rst_n)
        stall_q |-> (wb.cti == prev_cti))
        else report_mismatch("stall_cti", $sampled(prev_cti), $sampled(wb.cti));

    a_beat_count: assert property (@(posedge wb_clk) disable iff (!rst_n)
        beat_cnt == ack_cnt)
        else report_mismatch("beat_count", $sampled(ack_cnt), $sampled(beat_cnt));

    a_done_beats: assert property (@(posedge wb_clk) disable iff (!rst_n)
        (boot_done && !done_q) |-> (int'(beat_cnt) == TOTAL_BEATS))
        else report_mismatch("done_beats", TOTAL_BEATS, $sampled(beat_cnt));

    a_idle_after_done: assert property (@(posedge wb_clk) disable iff (!rst_n)
        boot_done |-> !wb.stb)
        else log_failure("stb raised after boot done");

    // ----------------------------------------------------------
    // Run
    // ----------------------------------------------------------
    initial begin
        int       cycles;
        wb_data_t exp_word;

        rst_n     = 1'b0;
        peek_addr = '0;
        repeat (RESET_CYCLES) @(posedge wb_clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        cycles = 0;
        while (!boot_done && cycles < DONE_TIMEOUT) begin
            @(negedge wb_clk);
            cycles++;
        end

        if (!boot_done) begin
            log_failure("boot done did not rise before the timeout");
        end else begin
            repeat (IDLE_CYCLES) @(negedge wb_clk);     // Bus must stay quiet
            for (int line_i = 0; line_i < HEX_LINES; line_i++) begin
                for (int beat_i = 0; beat_i < BEATS_PER_LINE; beat_i++) begin
                    peek_addr = wb_addr_t'(line_i * LINE_BYTES + beat_i * (WB_DATA_W / 8));
                    #DRIVE_DLY;
                    exp_word = image[line_i][beat_i*WB_DATA_W +: WB_DATA_W];
                    assert (peek_data == exp_word)
                        else report_mismatch("memory_image", exp_word, peek_data);
                end
            end
        end

        $display("Errors: %0d, beats written: %0d, cycles to done: %0d",
                 err_cnt, beat_cnt, cycles);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/wb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module wb_mem_model
    import wb_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  wb_req_t     i_wb,
    output logic        o_ack,
    output logic [15:0] o_beat_cnt,

    // Backdoor read for the final memory compare
    input  wb_addr_t    i_peek_addr,
    output wb_data_t    o_peek_data
);

    localparam int  MEM_WORDS = 64;
    localparam int  MAX_WAIT  = 3;
    localparam int  SEED      = 46737;
    localparam time ACK_DLY   = 2;

    wb_data_t    mem [MEM_WORDS];
    logic [15:0] beat_cnt;
    int unsigned wait_left;
    logic        armed;                             // Stall length drawn for this beat
    logic        ack_next;
    logic        write_now;
    wb_addr_t    addr_s;
    wb_data_t    data_s;

    function automatic int unsigned word_index(input wb_addr_t addr);
        return int'((addr >> 2) % MEM_WORDS);
    endfunction

    // ----------------------------------------------------------
    // Slave ack and write timing
    // ----------------------------------------------------------
    initial begin
        void'($urandom(SEED));
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (wb_data_t'(i) * 32'h9e37_79b1) ^ 32'hfeed_0000;
        end
        o_ack     = 1'b0;
        beat_cnt  = '0;
        wait_left = 0;
        armed     = 1'b0;
        write_now = 1'b0;
        forever begin
            @(negedge i_clk);
            write_now = 1'b0;
            if (i_rst_n && o_ack) begin
                write_now = i_wb.cyc && i_wb.stb && i_wb.we;    // Beat taken at next edge
                addr_s    = i_wb.addr;
                data_s    = i_wb.data;
            end
            @(posedge i_clk);
            #ACK_DLY;
            if (write_now) begin
                mem[word_index(addr_s)] = data_s;
                beat_cnt                = beat_cnt + 16'd1;
            end
            ack_next = 1'b0;
            if (!i_rst_n || o_ack) begin
                armed = 1'b0;                       // Next beat draws a fresh stall
            end
            if (i_rst_n && i_wb.cyc && i_wb.stb) begin
                if (!armed) begin
                    wait_left = $urandom % (MAX_WAIT + 1);
                    armed     = 1'b1;
                end
                if (wait_left == 0) begin
                    ack_next = 1'b1;
                end else begin
                    wait_left = wait_left - 1;
                end
            end
            o_ack = ack_next;
        end
    end

    assign o_beat_cnt  = beat_cnt;
    assign o_peek_data = mem[word_index(i_peek_addr)];

endmodule

`default_nettype wire
